//--- hdl/commit_pkg.sv
package commit_pkg;

    localparam int ROB_ID_W  = 6;
    localparam int ARCH_ID_W = 5;

    typedef logic [31:0]          word_t;
    typedef logic [ROB_ID_W-1:0]  rob_rid_t;
    typedef logic [ARCH_ID_W-1:0] arch_rid_t;

    // reduced csr set
    localparam logic [8:0] CSR_CRMD   = 9'h000;
    localparam logic [8:0] CSR_PRMD   = 9'h001;
    localparam logic [8:0] CSR_ESTAT  = 9'h005;
    localparam logic [8:0] CSR_ERA    = 9'h006;
    localparam logic [8:0] CSR_BADV   = 9'h007;
    localparam logic [8:0] CSR_EENTRY = 9'h00c;
    localparam logic [8:0] CSR_SAVE0  = 9'h030;
    localparam logic [8:0] CSR_SAVE1  = 9'h031;

    // estat ecode values
    localparam logic [5:0] ECODE_ADEF = 6'h08;
    localparam logic [5:0] ECODE_INE  = 6'h0d;
    localparam logic [5:0] ECODE_SYS  = 6'h0b;
    localparam logic [5:0] ECODE_BRK  = 6'h0c;
    localparam logic [5:0] ECODE_ALE  = 6'h09;

    localparam word_t CRMD_RESET = 32'h0000_0008; // direct address mode

    // bits that csr instructions may change
    localparam word_t CRMD_WMASK   = 32'h0000_01ff;
    localparam word_t PRMD_WMASK   = 32'h0000_0007;
    localparam word_t ESTAT_WMASK  = 32'h0000_0003; // software interrupt bits
    localparam word_t EENTRY_WMASK = 32'hffff_ffc0;

    typedef struct packed {
        logic slot0_only;
        logic jump_inst;
        logic lsu_inst;
        logic mem_write;
        logic csr_op_en;
        logic ertn_inst;
        logic priv_inst;
    } decode_info_t;

    typedef struct packed {
        logic adef;
        logic ine;
        logic sys;
        logic brk;
        logic ale;
    } excp_t;

    typedef struct packed {
        word_t        pc;
        word_t        wdata;
        word_t        target_addr; // branch target, mem address or csr mask
        arch_rid_t    wreg;
        logic [8:0]   csr_id;
        logic [4:0]   op_code;
        logic         need_jump;
        logic         pred_taken;
        word_t        pred_pc;
        logic         uncached;
        logic         excp_found;
        excp_t        excp;
        decode_info_t di;
    } rob_entry_t;

    typedef struct packed {
        logic valid;
        logic uncached_load_req;
        logic uncached_store_req;
        logic refill_store_req;
        logic storebuf_commit;
    } lsu_req_t;

    typedef struct packed {
        logic  ready;
        logic  storebuf_hit;
        word_t uncached_load_data;
    } lsu_resp_t;

    typedef struct packed {
        logic  redirect;
        logic  miss;
        word_t pc;
        word_t target;
    } redirect_t;

    typedef struct packed {
        word_t crmd;
        word_t prmd;
        word_t estat;
        word_t era;
        word_t badv;
        word_t eentry;
        word_t save0;
        word_t save1;
    } csr_t;

    typedef struct packed {
        logic       we;
        logic [8:0] id;
        word_t      mask;
        word_t      wdata;
        logic       excp_we;
        logic [5:0] ecode;
        logic       badv_we;
        word_t      badv;
        word_t      era;
        logic       ertn;
    } csr_write_t;

    typedef enum logic [2:0] {
        S_NORMAL,
        S_WAIT_ULOAD,
        S_WAIT_USTORE,
        S_WAIT_MSTORE,
        S_WAIT_FLUSH
    } commit_state_t;

endpackage

//--- hdl/commit_rob_fetch.sv
module commit_rob_fetch
    import commit_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    output rob_rid_t   [1:0] c_rrrid_o,
    input  logic       [1:0] c_rob_valid_i,
    input  rob_entry_t [1:0] c_rob_entry_i,
    output logic       [1:0] c_retire_o,
    output logic       [1:0] h_valid_o,
    output rob_entry_t [1:0] h_entry_o,
    output rob_rid_t   [1:0] h_wrrid_o,
    input  logic             h_ready_i,
    input  logic             flush_i
);

    rob_rid_t         ptr0_q;
    rob_rid_t         ptr1_q;
    rob_rid_t         n_pop;
    logic             bank_conflict;
    logic             ctrl_conflict;
    logic [1:0]       f_valid;
    logic             skid_empty_q;
    logic [1:0]       skid_valid_q;
    rob_entry_t [1:0] skid_entry_q;
    rob_rid_t [1:0]   skid_wrrid_q;

    // both write the same arf bank
    assign bank_conflict = (c_rob_entry_i[1].wreg[0] == c_rob_entry_i[0].wreg[0]) &&
                           (c_rob_entry_i[0].wreg != '0);
    assign ctrl_conflict = c_rob_entry_i[1].di.slot0_only || c_rob_entry_i[1].excp_found;

    // slot 1 never retires alone
    assign f_valid[0] = c_rob_valid_i[0];
    assign f_valid[1] = c_rob_valid_i[1] && c_rob_valid_i[0] && !bank_conflict &&
                        (!ctrl_conflict || flush_i); // squashed anyway during flush

    assign c_rrrid_o  = {ptr1_q, ptr0_q};
    assign c_retire_o = skid_empty_q ? f_valid : 2'b00; // no pop while replaying
    assign n_pop      = rob_rid_t'(c_retire_o[0]) + rob_rid_t'(c_retire_o[1]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr0_q <= rob_rid_t'(0);
            ptr1_q <= rob_rid_t'(1);
        end else begin
            ptr0_q <= ptr0_q + n_pop;
            ptr1_q <= ptr1_q + n_pop;
        end
    end

    // skid buffer, holds one pair while h stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            skid_empty_q <= 1'b1;
            skid_valid_q <= '0;
        end else if (skid_empty_q) begin
            if (!h_ready_i && (|f_valid)) begin
                skid_empty_q <= 1'b0;
                skid_valid_q <= f_valid;
            end
        end else if (h_ready_i) begin
            skid_empty_q <= 1'b1;
            skid_valid_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (skid_empty_q) begin
            skid_entry_q <= c_rob_entry_i;
            skid_wrrid_q <= c_rrrid_o;
        end
    end

    assign h_valid_o = skid_empty_q ? f_valid       : skid_valid_q;
    assign h_entry_o = skid_empty_q ? c_rob_entry_i : skid_entry_q;
    assign h_wrrid_o = skid_empty_q ? c_rrrid_o     : skid_wrrid_q;

endmodule

//--- hdl/commit_csr_file.sv
module commit_csr_file
    import commit_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [8:0] csr_rd_id_i,
    output word_t      csr_rdata_o,
    input  csr_write_t csr_cmd_i,
    input  logic       h_ready_i,
    output csr_t       csr_o
);

    csr_t csr_q;
    csr_t csr_d;

    function automatic word_t wmerge(word_t old_v, word_t new_v, word_t m);
        return (old_v & ~m) | (new_v & m);
    endfunction

    // read port for the entry entering h
    always_comb begin
        case (csr_rd_id_i)
            CSR_CRMD:   csr_rdata_o = csr_q.crmd;
            CSR_PRMD:   csr_rdata_o = csr_q.prmd;
            CSR_ESTAT:  csr_rdata_o = csr_q.estat;
            CSR_ERA:    csr_rdata_o = csr_q.era;
            CSR_BADV:   csr_rdata_o = csr_q.badv;
            CSR_EENTRY: csr_rdata_o = csr_q.eentry;
            CSR_SAVE0:  csr_rdata_o = csr_q.save0;
            CSR_SAVE1:  csr_rdata_o = csr_q.save1;
            default:    csr_rdata_o = '0;
        endcase
    end

    always_comb begin
        csr_d = csr_q;
        if (csr_cmd_i.we) begin
            case (csr_cmd_i.id)
                CSR_CRMD: begin
                    csr_d.crmd = wmerge(csr_q.crmd, csr_cmd_i.wdata, csr_cmd_i.mask & CRMD_WMASK);
                end
                CSR_PRMD: begin
                    csr_d.prmd = wmerge(csr_q.prmd, csr_cmd_i.wdata, csr_cmd_i.mask & PRMD_WMASK);
                end
                CSR_ESTAT: begin
                    csr_d.estat = wmerge(csr_q.estat, csr_cmd_i.wdata,
                                         csr_cmd_i.mask & ESTAT_WMASK);
                end
                CSR_ERA: begin
                    csr_d.era = wmerge(csr_q.era, csr_cmd_i.wdata, csr_cmd_i.mask);
                end
                CSR_BADV: begin
                    csr_d.badv = wmerge(csr_q.badv, csr_cmd_i.wdata, csr_cmd_i.mask);
                end
                CSR_EENTRY: begin
                    csr_d.eentry = wmerge(csr_q.eentry, csr_cmd_i.wdata,
                                          csr_cmd_i.mask & EENTRY_WMASK);
                end
                CSR_SAVE0: begin
                    csr_d.save0 = wmerge(csr_q.save0, csr_cmd_i.wdata, csr_cmd_i.mask);
                end
                CSR_SAVE1: begin
                    csr_d.save1 = wmerge(csr_q.save1, csr_cmd_i.wdata, csr_cmd_i.mask);
                end
                default: ; // unknown ids are ignored
            endcase
        end

        // exception entry
        if (csr_cmd_i.excp_we) begin
            csr_d.estat[21:16] = csr_cmd_i.ecode;
            csr_d.prmd[2:0]    = csr_q.crmd[2:0]; // save plv and ie
            csr_d.crmd[2:0]    = 3'b000;          // kernel, interrupts off
            csr_d.era          = csr_cmd_i.era;
            if (csr_cmd_i.badv_we) begin
                csr_d.badv = csr_cmd_i.badv;
            end
        end

        if (csr_cmd_i.ertn) begin
            csr_d.crmd[2:0] = csr_q.prmd[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_q <= '{crmd: CRMD_RESET, default: '0};
        end else if (h_ready_i) begin
            csr_q <= csr_d;
        end
    end

    assign csr_o = csr_q;

endmodule

//--- hdl/commit_fsm.sv
module commit_fsm
    import commit_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic       [1:0] h_valid_i,
    input  rob_entry_t [1:0] h_entry_i,
    input  rob_rid_t   [1:0] h_wrrid_i,
    output logic             h_ready_o,
    output logic       [8:0] csr_rd_id_o,
    input  word_t            csr_rdata_i,
    output csr_write_t       csr_cmd_o,
    input  csr_t             csr_i,
    output lsu_req_t         c_lsu_req_o,
    input  lsu_resp_t        c_lsu_resp_i,
    output logic       [1:0] l_retire_o,
    output logic       [1:0] l_commit_o,
    output word_t      [1:0] l_data_o,
    output arch_rid_t  [1:0] l_warid_o,
    output rob_rid_t   [1:0] l_wrrid_o,
    output redirect_t        f_upd_o,
    output logic             l_flush_o,
    input  logic             rename_empty_i
);

    rob_entry_t [1:0] h_entry_q;
    rob_rid_t [1:0]   h_wrrid_q;
    logic [1:0]       h_valid_q;
    word_t            h_rdata_q;    // csr value seen by slot 0
    commit_state_t    state_q;
    commit_state_t    state_d;
    rob_entry_t       e0;
    word_t            pc_next;
    word_t            csr_mask;
    logic             mispredict;
    logic [1:0]       l_retire;
    logic [1:0]       l_commit;
    word_t [1:0]      l_data;
    logic             l_flush;
    redirect_t        f_upd;

    assign csr_rd_id_o = h_entry_i[0].csr_id;

    // h stage
    always_ff @(posedge clk) begin
        if (h_ready_o) begin
            h_entry_q <= h_entry_i;
            h_wrrid_q <= h_wrrid_i;
            h_rdata_q <= csr_rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_valid_q <= '0;
            state_q   <= S_NORMAL;
        end else begin
            if (h_ready_o) begin
                h_valid_q <= h_valid_i;
            end
            state_q <= state_d;
        end
    end

    assign e0         = h_entry_q[0];
    assign pc_next    = e0.pc + 32'd4;
    assign mispredict = e0.di.jump_inst &&
                        ((e0.need_jump != e0.pred_taken) ||
                         (e0.need_jump && (e0.pred_pc != e0.target_addr)));
    // op 0 reads only, op 1 writes all, else mask comes in target_addr
    assign csr_mask   = (e0.op_code == 5'd0) ? '0 :
                        (e0.op_code == 5'd1) ? '1 : e0.target_addr;

    always_comb begin
        state_d         = state_q;
        h_ready_o       = 1'b1;
        c_lsu_req_o     = '0;
        l_retire        = '0;
        l_commit        = '0;
        l_flush         = 1'b0;
        l_data          = {h_entry_q[1].wdata, e0.wdata};
        f_upd           = '0;
        f_upd.pc        = e0.pc;
        f_upd.target    = pc_next;
        csr_cmd_o       = '0;
        csr_cmd_o.id    = e0.csr_id;
        csr_cmd_o.mask  = csr_mask;
        csr_cmd_o.wdata = e0.wdata;
        csr_cmd_o.era   = e0.pc;
        case (state_q)
            S_NORMAL: begin
                l_retire = h_valid_q;
                l_commit = h_valid_q;
                if (h_valid_q[0] && e0.excp_found) begin
                    l_commit          = 2'b00;
                    f_upd.redirect    = 1'b1;
                    f_upd.target      = csr_i.eentry;
                    csr_cmd_o.excp_we = 1'b1;
                    state_d           = S_WAIT_FLUSH;
                    if (e0.excp.adef) begin
                        csr_cmd_o.ecode   = ECODE_ADEF;
                        csr_cmd_o.badv_we = 1'b1;
                        csr_cmd_o.badv    = e0.pc;
                    end else if (e0.excp.ine) begin
                        csr_cmd_o.ecode = ECODE_INE;
                    end else if (e0.excp.sys) begin
                        csr_cmd_o.ecode = ECODE_SYS;
                    end else if (e0.excp.brk) begin
                        csr_cmd_o.ecode = ECODE_BRK;
                    end else if (e0.excp.ale) begin
                        csr_cmd_o.ecode   = ECODE_ALE;
                        csr_cmd_o.badv_we = 1'b1;
                        csr_cmd_o.badv    = e0.target_addr; // faulting address
                    end
                end else if (h_valid_q[0]) begin
                    if (e0.di.lsu_inst && e0.uncached) begin
                        h_ready_o = 1'b0; // commit once lsu answers
                        l_retire  = 2'b00;
                        l_commit  = 2'b00;
                        state_d   = e0.di.mem_write ? S_WAIT_USTORE : S_WAIT_ULOAD;
                    end else if (e0.di.lsu_inst && e0.di.mem_write) begin
                        if (c_lsu_resp_i.storebuf_hit) begin
                            c_lsu_req_o.storebuf_commit = 1'b1;
                        end else begin
                            h_ready_o = 1'b0; // line must be refilled first
                            l_retire  = 2'b00;
                            l_commit  = 2'b00;
                            state_d   = S_WAIT_MSTORE;
                        end
                    end
                    if (mispredict) begin
                        l_commit       = 2'b01;
                        f_upd.redirect = 1'b1;
                        f_upd.miss     = 1'b1;
                        f_upd.target   = e0.need_jump ? e0.target_addr : pc_next;
                        state_d        = S_WAIT_FLUSH;
                    end
                    if (e0.di.csr_op_en) begin
                        l_data[0]    = h_rdata_q; // old value to rd
                        csr_cmd_o.we = 1'b1;
                    end
                    // csr side effects only seen by refetched code
                    if (e0.di.priv_inst || e0.di.csr_op_en) begin
                        l_commit       = 2'b01;
                        f_upd.redirect = 1'b1;
                        f_upd.target   = e0.di.ertn_inst ? csr_i.era : pc_next;
                        csr_cmd_o.ertn = e0.di.ertn_inst;
                        state_d        = S_WAIT_FLUSH;
                    end
                end
            end
            S_WAIT_ULOAD, S_WAIT_USTORE, S_WAIT_MSTORE: begin
                c_lsu_req_o.valid              = 1'b1;
                c_lsu_req_o.uncached_load_req  = (state_q == S_WAIT_ULOAD);
                c_lsu_req_o.uncached_store_req = (state_q == S_WAIT_USTORE);
                c_lsu_req_o.refill_store_req   = (state_q == S_WAIT_MSTORE);
                h_ready_o                      = c_lsu_resp_i.ready;
                if (c_lsu_resp_i.ready) begin
                    l_retire = h_valid_q;
                    if (state_q == S_WAIT_ULOAD) begin
                        l_commit       = 2'b01;
                        l_data[0]      = c_lsu_resp_i.uncached_load_data;
                        f_upd.redirect = 1'b1; // younger loads may have read stale data
                        state_d        = S_WAIT_FLUSH;
                    end else begin
                        l_commit = h_valid_q;
                        state_d  = S_NORMAL;
                    end
                end
            end
            S_WAIT_FLUSH: begin
                l_flush  = 1'b1;
                l_retire = h_valid_q; // drain wrong path, no arf writes
                if (rename_empty_i) begin
                    state_d = S_NORMAL;
                end
            end
            default: state_d = S_NORMAL;
        endcase
    end

    // c stage
    always_ff @(posedge clk) begin
        l_data_o  <= l_data;
        l_warid_o <= {h_entry_q[1].wreg, e0.wreg};
        l_wrrid_o <= h_wrrid_q;
        f_upd_o   <= f_upd;
        if (!rst_n) begin
            l_retire_o       <= '0;
            l_commit_o       <= '0;
            l_flush_o        <= 1'b0;
            f_upd_o.redirect <= 1'b0;
            f_upd_o.miss     <= 1'b0;
        end else begin
            l_retire_o <= l_retire;
            l_commit_o <= l_commit;
            l_flush_o  <= l_flush;
        end
    end

endmodule

//--- hdl/commit_top.sv
module commit_top
    import commit_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    output rob_rid_t   [1:0] c_rrrid_o,
    input  logic       [1:0] c_rob_valid_i,
    input  rob_entry_t [1:0] c_rob_entry_i,
    output logic       [1:0] c_retire_o,
    output lsu_req_t         c_lsu_req_o,
    input  lsu_resp_t        c_lsu_resp_i,
    output logic       [1:0] l_retire_o,
    output logic       [1:0] l_commit_o,
    output word_t      [1:0] l_data_o,
    output arch_rid_t  [1:0] l_warid_o,
    output rob_rid_t   [1:0] l_wrrid_o,
    output redirect_t        f_upd_o,
    output logic             l_flush_o,
    input  logic             rename_empty_i,
    output csr_t             csr_o
);

    logic [1:0]       h_valid;
    rob_entry_t [1:0] h_entry;
    rob_rid_t [1:0]   h_wrrid;
    logic             h_ready;
    logic [8:0]       csr_rd_id;
    word_t            csr_rdata;
    csr_write_t       csr_cmd;

    commit_rob_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .c_rrrid_o     (c_rrrid_o),
        .c_rob_valid_i (c_rob_valid_i),
        .c_rob_entry_i (c_rob_entry_i),
        .c_retire_o    (c_retire_o),
        .h_valid_o     (h_valid),
        .h_entry_o     (h_entry),
        .h_wrrid_o     (h_wrrid),
        .h_ready_i     (h_ready),
        .flush_i       (l_flush_o)
    );

    commit_csr_file u_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_rd_id_i (csr_rd_id),
        .csr_rdata_o (csr_rdata),
        .csr_cmd_i   (csr_cmd),
        .h_ready_i   (h_ready),
        .csr_o       (csr_o)
    );

    commit_fsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .h_valid_i      (h_valid),
        .h_entry_i      (h_entry),
        .h_wrrid_i      (h_wrrid),
        .h_ready_o      (h_ready),
        .csr_rd_id_o    (csr_rd_id),
        .csr_rdata_i    (csr_rdata),
        .csr_cmd_o      (csr_cmd),
        .csr_i          (csr_o),
        .c_lsu_req_o    (c_lsu_req_o),
        .c_lsu_resp_i   (c_lsu_resp_i),
        .l_retire_o     (l_retire_o),
        .l_commit_o     (l_commit_o),
        .l_data_o       (l_data_o),
        .l_warid_o      (l_warid_o),
        .l_wrrid_o      (l_wrrid_o),
        .f_upd_o        (f_upd_o),
        .l_flush_o      (l_flush_o),
        .rename_empty_i (rename_empty_i)
    );

endmodule

//--- tests/commit_properties.sv
module commit_properties
    import commit_pkg::*;
(
    input logic             clk,
    input logic             rst_n,
    input rob_rid_t   [1:0] c_rrrid_o,
    input logic       [1:0] c_retire_o,
    input rob_entry_t [1:0] c_rob_entry_i,
    input logic             h_ready,
    input logic       [1:0] h_valid_q,
    input rob_entry_t       e0,
    input commit_state_t    state,
    input logic       [1:0] l_retire_o,
    input logic       [1:0] l_commit_o,
    input word_t      [1:0] l_data_o,
    input arch_rid_t  [1:0] l_warid_o,
    input rob_rid_t   [1:0] l_wrrid_o,
    input logic             l_flush_o,
    input logic             rename_empty_i,
    input redirect_t        f_upd_o,
    input csr_t             csr_o,
    input lsu_req_t         c_lsu_req_o,
    input lsu_resp_t        c_lsu_resp_i
);

    int        fail_cnt = 0;
    rob_rid_t  exp_id;                     // next rob id due on slot 0
    arch_rid_t popped_wreg [2**ROB_ID_W];  // dest reg of each id when it left the rob
    logic      h0_ok;  // slot 0 in h commits normally

    assign h0_ok = (state == S_NORMAL) && h_valid_q[0] && !e0.excp_found;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exp_id <= '0;
        end else if (l_retire_o[0]) begin
            exp_id <= exp_id + (l_retire_o[1] ? 6'd2 : 6'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (c_retire_o[0]) begin
            popped_wreg[c_rrrid_o[0]] <= c_rob_entry_i[0].wreg;
        end
        if (c_retire_o[1]) begin
            popped_wreg[c_rrrid_o[1]] <= c_rob_entry_i[1].wreg;
        end
    end

    a_no_slot1_alone: assert property (@(posedge clk) disable iff (!rst_n)
        c_retire_o != 2'b10)
    else begin
        $error("slot 1 retired alone");
        fail_cnt++;
    end

    a_dual_ok: assert property (@(posedge clk) disable iff (!rst_n)
        c_retire_o == 2'b11 |->
            ((c_rob_entry_i[1].wreg[0] != c_rob_entry_i[0].wreg[0]) ||
             (c_rob_entry_i[0].wreg == '0)) &&
            ((!c_rob_entry_i[1].di.slot0_only && !c_rob_entry_i[1].excp_found) || l_flush_o))
    else begin
        $error("illegal dual retire");
        fail_cnt++;
    end

    a_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        l_retire_o[0] |-> l_wrrid_o[0] == exp_id)
    else begin
        $error("FAILED %0t l_wrrid_o[0] %0d expected %0d", $time,
               $sampled(l_wrrid_o[0]), $sampled(exp_id));
        fail_cnt++;
    end

    a_warid0: assert property (@(posedge clk) disable iff (!rst_n)
        l_retire_o[0] |-> l_warid_o[0] == popped_wreg[l_wrrid_o[0]])
    else begin
        $error("FAILED %0t l_warid_o[0] %0d expected %0d", $time,
               $sampled(l_warid_o[0]), popped_wreg[$sampled(l_wrrid_o[0])]);
        fail_cnt++;
    end

    a_warid1: assert property (@(posedge clk) disable iff (!rst_n)
        l_retire_o[1] |-> l_warid_o[1] == popped_wreg[l_wrrid_o[1]])
    else begin
        $error("FAILED %0t l_warid_o[1] %0d expected %0d", $time,
               $sampled(l_warid_o[1]), popped_wreg[$sampled(l_wrrid_o[1])]);
        fail_cnt++;
    end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(h_ready, 2) && $past(h_ready) && ($past(c_retire_o, 2) != 2'b00) |->
            l_retire_o == $past(c_retire_o, 2))
    else begin
        $error("retire latency wrong");
        fail_cnt++;
    end

    a_sys: assert property (@(posedge clk) disable iff (!rst_n)
        (state == S_NORMAL) && h_valid_q[0] && e0.excp_found && e0.excp.sys &&
        !e0.excp.adef && !e0.excp.ine |=>
            (l_commit_o == 2'b00) && f_upd_o.redirect &&
            (f_upd_o.target == $past(csr_o.eentry)) &&
            (csr_o.estat[21:16] == ECODE_SYS) && (csr_o.era == $past(e0.pc)))
    else begin
        $error("sys exception handled wrong");
        fail_cnt++;
    end

    a_flush_hold: assert property (@(posedge clk) disable iff (!rst_n)
        l_flush_o && !$past(rename_empty_i) |=> l_flush_o)
    else begin
        $error("flush dropped early");
        fail_cnt++;
    end

    a_flush_end: assert property (@(posedge clk) disable iff (!rst_n)
        l_flush_o && $past(rename_empty_i) |=> !l_flush_o)
    else begin
        $error("flush held too long");
        fail_cnt++;
    end

    a_mispredict: assert property (@(posedge clk) disable iff (!rst_n)
        h0_ok && e0.di.jump_inst && (e0.need_jump != e0.pred_taken) &&
        !e0.di.csr_op_en && !e0.di.priv_inst |=>
            f_upd_o.redirect && f_upd_o.miss && (f_upd_o.pc == $past(e0.pc)) &&
            (f_upd_o.target == ($past(e0.need_jump) ? $past(e0.target_addr) :
                                $past(e0.pc) + 32'd4)))
    else begin
        $error("mispredict redirect wrong");
        fail_cnt++;
    end

    // request raised for an uncached load and held until ready
    a_uload_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (h0_ok && e0.di.lsu_inst && e0.uncached && !e0.di.mem_write) ||
        (c_lsu_req_o.valid && c_lsu_req_o.uncached_load_req && !c_lsu_resp_i.ready) |=>
            c_lsu_req_o.valid && c_lsu_req_o.uncached_load_req)
    else begin
        $error("uncached load request dropped");
        fail_cnt++;
    end

    a_uload_done: assert property (@(posedge clk) disable iff (!rst_n)
        (state == S_WAIT_ULOAD) && c_lsu_resp_i.ready |=>
            !c_lsu_req_o.valid && (l_commit_o == 2'b01) &&
            (l_data_o[0] == $past(c_lsu_resp_i.uncached_load_data)))
    else begin
        $error("uncached load commit wrong");
        fail_cnt++;
    end

    a_csrxchg: assert property (@(posedge clk) disable iff (!rst_n)
        h0_ok && e0.di.csr_op_en && (e0.csr_id == CSR_SAVE0) && (e0.op_code == 5'd2) |=>
            (l_data_o[0] == $past(csr_o.save0)) &&
            (csr_o.save0 == (($past(csr_o.save0) & ~$past(e0.target_addr)) |
                             ($past(e0.wdata) & $past(e0.target_addr)))))
    else begin
        $error("csrxchg on save0 wrong");
        fail_cnt++;
    end

endmodule

bind commit_top commit_properties u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .c_rrrid_o      (c_rrrid_o),
    .c_retire_o     (c_retire_o),
    .c_rob_entry_i  (c_rob_entry_i),
    .h_ready        (h_ready),
    .h_valid_q      (u_fsm.h_valid_q),
    .e0             (u_fsm.e0),
    .state          (u_fsm.state_q),
    .l_retire_o     (l_retire_o),
    .l_commit_o     (l_commit_o),
    .l_data_o       (l_data_o),
    .l_warid_o      (l_warid_o),
    .l_wrrid_o      (l_wrrid_o),
    .l_flush_o      (l_flush_o),
    .rename_empty_i (rename_empty_i),
    .f_upd_o        (f_upd_o),
    .csr_o          (csr_o),
    .c_lsu_req_o    (c_lsu_req_o),
    .c_lsu_resp_i   (c_lsu_resp_i)
);

//--- tests/tb_commit.sv
module tb_commit
    import commit_pkg::*;
();

    logic             clk;
    logic             rst_n;
    rob_rid_t   [1:0] c_rrrid_o;
    logic       [1:0] c_rob_valid_i;
    rob_entry_t [1:0] c_rob_entry_i;
    logic       [1:0] c_retire_o;
    lsu_req_t         c_lsu_req_o;
    lsu_resp_t        c_lsu_resp_i;
    logic       [1:0] l_retire_o;
    logic       [1:0] l_commit_o;
    word_t      [1:0] l_data_o;
    arch_rid_t  [1:0] l_warid_o;
    rob_rid_t   [1:0] l_wrrid_o;
    redirect_t        f_upd_o;
    logic             l_flush_o;
    logic             rename_empty_i;
    csr_t             csr_o;

    int         seed = 63745;
    int         timeouts = 0;
    rob_entry_t rob_mem [64];
    logic [6:0] n_alloc = '0;    // entries written into the rob model
    word_t      next_pc = 32'h1c00_0000;

    commit_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one falling edge, then new rob view, lsu answer and rename status
    task automatic step();
        word_t r;
        @(negedge clk);
        r = $random(seed);
        // either slot may still be executing
        c_rob_valid_i[0] = ({1'b0, c_rrrid_o[0]} < n_alloc) && (r[7:5] != 3'b000);
        c_rob_valid_i[1] = ({1'b0, c_rrrid_o[1]} < n_alloc) && (r[7:5] != 3'b111);
        c_rob_entry_i[0] = rob_mem[c_rrrid_o[0]];
        c_rob_entry_i[1] = rob_mem[c_rrrid_o[1]];
        rename_empty_i = (r[1:0] == 2'b00);
        c_lsu_resp_i.ready = c_lsu_req_o.valid && (r[3:2] == 2'b11);
        c_lsu_resp_i.storebuf_hit = r[4];
        c_lsu_resp_i.uncached_load_data = {r[31:8], 8'h5c};
    endtask

    task automatic make_entry(output rob_entry_t e);
        word_t r;
        r = $random(seed);
        e = '0;
        e.pc = next_pc;
        e.wdata = {r[31:5], 5'h0} ^ next_pc;
        e.wreg = r[4:0];
        next_pc = next_pc + 32'd4;
    endtask

    task automatic push(input rob_entry_t e);
        rob_mem[n_alloc[5:0]] = e;
        n_alloc = n_alloc + 7'd1;
    endtask

    // run until the rob is empty and the commit stage has gone quiet
    task automatic drain();
        int idle;
        int t;
        idle = 0;
        for (t = 0; t < 500 && idle < 4; t++) begin
            step();
            if ({1'b0, c_rrrid_o[0]} == n_alloc && l_retire_o == 2'b00 && !l_flush_o &&
                !c_lsu_req_o.valid) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
        if (idle < 4) begin
            timeouts++;
            $display("timeout at %0t: commit stage did not drain", $time);
        end
    endtask

    initial begin
        rob_entry_t e;
        int         i;
        word_t      r;
        rst_n = 1'b0;
        c_rob_valid_i = '0;
        c_rob_entry_i = '0;
        c_lsu_resp_i = '0;
        rename_empty_i = 1'b0;
        for (i = 0; i < 64; i++) begin
            rob_mem[i] = '0;
        end
        repeat (3) step();
        rst_n = 1'b1;

        for (i = 0; i < 12; i++) begin // plain alu pairs
            make_entry(e);
            push(e);
        end
        drain();

        make_entry(e);                 // syscall then a younger op
        e.excp_found = 1'b1;
        e.excp.sys = 1'b1;
        push(e);
        make_entry(e);
        push(e);
        drain();

        for (i = 0; i < 2; i++) begin  // taken and not-taken mispredicts
            make_entry(e);
            e.di.jump_inst = 1'b1;
            e.need_jump = (i == 0);
            e.pred_taken = (i != 0);
            e.target_addr = 32'h1c00_4000;
            push(e);
            make_entry(e);
            push(e);
            drain();
        end

        make_entry(e);                 // uncached load
        e.di.lsu_inst = 1'b1;
        e.uncached = 1'b1;
        push(e);
        make_entry(e);
        push(e);
        drain();

        for (i = 0; i < 4; i++) begin  // uncached store and buffered stores
            make_entry(e);
            e.di.lsu_inst = 1'b1;
            e.di.mem_write = 1'b1;
            e.di.slot0_only = 1'b1;    // lsu ops never retire as slot 1
            e.uncached = (i == 0);
            push(e);
        end
        drain();

        make_entry(e);                 // csrwr then csrxchg on save0
        e.di.csr_op_en = 1'b1;
        e.di.slot0_only = 1'b1;
        e.csr_id = CSR_SAVE0;
        e.op_code = 5'd1;
        e.wdata = 32'hdead_beef;
        push(e);
        drain();
        make_entry(e);
        e.di.csr_op_en = 1'b1;
        e.di.slot0_only = 1'b1;
        e.csr_id = CSR_SAVE0;
        e.op_code = 5'd2;
        e.wdata = 32'h1234_5678;
        e.target_addr = 32'hff00_f0f0;
        push(e);
        drain();

        make_entry(e);                 // ertn
        e.di.priv_inst = 1'b1;
        e.di.ertn_inst = 1'b1;
        e.di.slot0_only = 1'b1;
        push(e);
        drain();

        for (i = 0; i < 14; i++) begin // random mix
            make_entry(e);
            r = $random(seed);
            e.di.lsu_inst = r[0];
            e.di.mem_write = r[1];
            e.uncached = r[2] & r[3];
            e.di.slot0_only = r[4] | r[0];
            push(e);
        end
        drain();

        $display("closing: %0d assertion failures, %0d timeouts", uut.u_props.fail_cnt,
                 timeouts);
        if (uut.u_props.fail_cnt == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/commit_pkg.sv
hdl/commit_rob_fetch.sv
hdl/commit_csr_file.sv
hdl/commit_fsm.sv
hdl/commit_top.sv
tests/commit_properties.sv
tests/tb_commit.sv

//--- Makefile
SRCS := $(wildcard hdl/*.sv tests/*.sv)

obj_dir/Vtb_commit: files.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_commit -f files.f

.PHONY: run clean

run: obj_dir/Vtb_commit
	@out="$$(./obj_dir/Vtb_commit)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
